/* rtl/ftalu_pkg.sv */
// shared constants, alu operation enum, lane index and lane mask types for the fault-tolerant alu
package ftalu_pkg;

	//////////////////////////////
	// replica arrangement
	//////////////////////////////

	// physical alu replicas, three voted plus one spare
	localparam int NUM_LANES = 4;
	// slots seen by the majority voter
	localparam int NUM_VOTED = 3;

	//////////////////////////////
	// operation encoding
	//////////////////////////////

	// integer operations kept from the rv32i execute stage
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		// signed compare, also drives the comparison flag
		ALU_SLT  = 4'd7,
		// unsigned compare, also drives the comparison flag
		ALU_SLTU = 4'd8
	} alu_op_t;

	// index of one physical lane
	typedef logic [1:0] lane_idx_t;

	// one bit per physical lane
	typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

/* rtl/ftalu_lane_alu.sv */
// one combinational alu lane with result lsb fault injection
`timescale 1ns/1ps

module ftalu_lane_alu #(
	parameter int DATA_W = 32
) (
	input  ftalu_pkg::alu_op_t op_i,
	input  logic [DATA_W-1:0]  operand_a_i,
	input  logic [DATA_W-1:0]  operand_b_i,
	// fault hook, flips bit 0 of the result
	input  logic               inj_i,
	output logic [DATA_W-1:0]  result_o,
	output logic               cmp_o
);

	// shift amount width follows the operand width
	localparam int SHAMT_W = $clog2(DATA_W);

	logic [SHAMT_W-1:0] shamt;
	logic               lt_signed;
	logic               lt_unsigned;
	logic [DATA_W-1:0]  alu_res;

	// only the low bits of operand b select the shift
	assign shamt       = operand_b_i[SHAMT_W-1:0];
	assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
	assign lt_unsigned = operand_a_i < operand_b_i;

	always_comb begin
		alu_res = '0;
		// flag stays low outside the set-less-than ops
		cmp_o   = 1'b0;
		case (op_i)
			ftalu_pkg::ALU_ADD: alu_res = operand_a_i + operand_b_i;
			ftalu_pkg::ALU_SUB: alu_res = operand_a_i - operand_b_i;
			ftalu_pkg::ALU_AND: alu_res = operand_a_i & operand_b_i;
			ftalu_pkg::ALU_OR:  alu_res = operand_a_i | operand_b_i;
			ftalu_pkg::ALU_XOR: alu_res = operand_a_i ^ operand_b_i;
			ftalu_pkg::ALU_SLL: alu_res = operand_a_i << shamt;
			ftalu_pkg::ALU_SRL: alu_res = operand_a_i >> shamt;
			ftalu_pkg::ALU_SLT: begin
				cmp_o   = lt_signed;
				alu_res = {{(DATA_W-1){1'b0}}, lt_signed};
			end
			ftalu_pkg::ALU_SLTU: begin
				cmp_o   = lt_unsigned;
				alu_res = {{(DATA_W-1){1'b0}}, lt_unsigned};
			end
			default: alu_res = '0;
		endcase
	end

	// injected fault only touches the result, not the flag
	assign result_o = {alu_res[DATA_W-1:1], alu_res[0] ^ inj_i};

endmodule

/* rtl/ftalu_spare_cfg.sv */
// configuration registers for spare lane selection and fault counter clear strobe
`timescale 1ns/1ps

module ftalu_spare_cfg (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 cfg_we_i,
	input  ftalu_pkg::lane_idx_t cfg_spare_i,
	input  logic                 cfg_clr_i,
	output ftalu_pkg::lane_idx_t spare_idx_o,
	output logic                 clr_o
);

	ftalu_pkg::lane_idx_t spare_q;
	logic                 clr_q;

	//////////////////////////////
	// spare lane register
	//////////////////////////////

	// out of reset the last lane is the spare
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			spare_q <= ftalu_pkg::lane_idx_t'(ftalu_pkg::NUM_LANES - 1);
		end else if (cfg_we_i) begin
			// new steering applies from the next cycle
			spare_q <= cfg_spare_i;
		end
	end

	//////////////////////////////
	// clear strobe
	//////////////////////////////

	// one cycle pulse toward the counters
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			clr_q <= 1'b0;
		end else begin
			clr_q <= cfg_clr_i;
		end
	end

	assign spare_idx_o = spare_q;
	assign clr_o       = clr_q;

endmodule

/* rtl/ftalu_vote_stage.sv */
// lane steering, 2-of-3 majority vote, per lane error attribution and registered output handshake
`timescale 1ns/1ps

module ftalu_vote_stage #(
	parameter int DATA_W = 32
) (
	input  logic                                         clk,
	input  logic                                         arst_n_i,
	input  logic                                         valid_i,
	input  logic                                         ready_i,
	input  logic [ftalu_pkg::NUM_LANES-1:0][DATA_W-1:0]  lane_result_i,
	input  ftalu_pkg::lane_mask_t                        lane_cmp_i,
	input  ftalu_pkg::lane_idx_t                         spare_idx_i,
	output logic                                         ready_o,
	output logic                                         valid_o,
	output logic [DATA_W-1:0]                            result_o,
	output logic                                         cmp_o,
	output logic                                         err_detected_o,
	output logic                                         err_corrected_o,
	output ftalu_pkg::lane_mask_t                        lane_err_o
);

	// result and comparison flag are voted as one word
	localparam int WORD_W = DATA_W + 1;

	ftalu_pkg::lane_idx_t [ftalu_pkg::NUM_VOTED-1:0]  slot_lane;
	logic [ftalu_pkg::NUM_VOTED-1:0][WORD_W-1:0]      slot_word;
	logic [WORD_W-1:0]                                voted_word;
	logic                                             m01;
	logic                                             m02;
	logic                                             m12;
	logic                                             detected;
	logic                                             corrected;
	ftalu_pkg::lane_mask_t                            lane_err_d;
	logic                                             accept;

	logic                  valid_q;
	logic [DATA_W-1:0]     result_q;
	logic                  cmp_q;
	logic                  det_q;
	logic                  corr_q;
	ftalu_pkg::lane_mask_t lane_err_q;

	//////////////////////////////
	// steering
	//////////////////////////////

	// slot k reads lane k unless it is the spare slot, which reads the last lane
	always_comb begin
		for (int k = 0; k < ftalu_pkg::NUM_VOTED; k++) begin
			if (spare_idx_i == ftalu_pkg::lane_idx_t'(k)) begin
				slot_lane[k] = ftalu_pkg::lane_idx_t'(ftalu_pkg::NUM_LANES - 1);
			end else begin
				slot_lane[k] = ftalu_pkg::lane_idx_t'(k);
			end
			slot_word[k] = {lane_result_i[slot_lane[k]], lane_cmp_i[slot_lane[k]]};
		end
	end

	//////////////////////////////
	// majority vote
	//////////////////////////////

	assign m01 = (slot_word[0] == slot_word[1]);
	assign m02 = (slot_word[0] == slot_word[2]);
	assign m12 = (slot_word[1] == slot_word[2]);

	// slot 0 wins on any match, then slot 1, else slot 0 passes through
	assign voted_word = (m01 || m02) ? slot_word[0] :
		(m12 ? slot_word[1] : slot_word[0]);

	// any pair differs
	assign detected  = !m01 || !m02 || !m12;
	// a majority still exists
	assign corrected = detected && (m01 || m02 || m12);

	// charge each disagreeing slot to the lane behind it
	always_comb begin
		lane_err_d = '0;
		for (int k = 0; k < ftalu_pkg::NUM_VOTED; k++) begin
			if (slot_word[k] != voted_word) begin
				lane_err_d[slot_lane[k]] = 1'b1;
			end
		end
	end

	//////////////////////////////
	// output register
	//////////////////////////////

	// free when empty or when the consumer takes the current beat
	assign ready_o = !valid_q || ready_i;
	assign accept  = valid_i && ready_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q    <= 1'b0;
			det_q      <= 1'b0;
			corr_q     <= 1'b0;
			lane_err_q <= '0;
		end else begin
			// error pulse only on accepted beats
			lane_err_q <= accept ? lane_err_d : '0;
			if (accept) begin
				valid_q <= 1'b1;
				det_q   <= detected;
				corr_q  <= corrected;
			end else if (ready_i) begin
				// beat left with nothing behind it
				valid_q <= 1'b0;
				det_q   <= 1'b0;
				corr_q  <= 1'b0;
			end
		end
	end

	// voted payload
	always_ff @(posedge clk) begin
		if (accept) begin
			result_q <= voted_word[WORD_W-1:1];
			cmp_q    <= voted_word[0];
		end
	end

	assign valid_o         = valid_q;
	assign result_o        = result_q;
	assign cmp_o           = cmp_q;
	assign err_detected_o  = det_q;
	assign err_corrected_o = corr_q;
	assign lane_err_o      = lane_err_q;

endmodule

/* rtl/ftalu_fault_counters.sv */
// per lane saturating error counters with sticky permanent fault flags and event pulses
`timescale 1ns/1ps

module ftalu_fault_counters #(
	parameter int ERR_THRESHOLD = 4,
	parameter int CNT_W         = 3
) (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  ftalu_pkg::lane_mask_t lane_err_i,
	input  logic                  clr_i,
	output ftalu_pkg::lane_mask_t permanent_fault_o,
	output ftalu_pkg::lane_mask_t fault_event_o
);

	// saturation point of every counter
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(ERR_THRESHOLD);

	logic [ftalu_pkg::NUM_LANES-1:0][CNT_W-1:0] cnt_q;
	ftalu_pkg::lane_mask_t                      perm_q;
	ftalu_pkg::lane_mask_t                      event_q;

	//////////////////////////////
	// counters and flags
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q   <= '0;
			perm_q  <= '0;
			event_q <= '0;
		end else if (clr_i) begin
			// clear wipes counts, flags and any pending event
			cnt_q   <= '0;
			perm_q  <= '0;
			event_q <= '0;
		end else begin
			for (int i = 0; i < ftalu_pkg::NUM_LANES; i++) begin
				// event is a single cycle pulse by default
				event_q[i] <= 1'b0;
				// counter holds once it reaches the threshold
				if (lane_err_i[i] && (cnt_q[i] != CNT_MAX)) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
					// this increment lands on the threshold
					if (cnt_q[i] == CNT_MAX - 1'b1) begin
						perm_q[i]  <= 1'b1;
						event_q[i] <= 1'b1;
					end
				end
			end
		end
	end

	assign permanent_fault_o = perm_q;
	assign fault_event_o     = event_q;

endmodule

/* rtl/ftalu_top.sv */
// top level with four alu lanes, spare configuration, majority vote stage and fault counters
`timescale 1ns/1ps

module ftalu_top #(
	parameter int DATA_W        = 32,
	parameter int ERR_THRESHOLD = 4,
	parameter int CNT_W         = 3
) (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  valid_i,
	input  ftalu_pkg::alu_op_t    op_i,
	input  logic [DATA_W-1:0]     operand_a_i,
	input  logic [DATA_W-1:0]     operand_b_i,
	input  logic                  ready_i,
	input  logic                  cfg_we_i,
	input  ftalu_pkg::lane_idx_t  cfg_spare_i,
	input  logic                  cfg_clr_i,
	input  ftalu_pkg::lane_mask_t inj_lane_i,
	output logic                  ready_o,
	output logic                  valid_o,
	output logic [DATA_W-1:0]     result_o,
	output logic                  cmp_o,
	output logic                  err_detected_o,
	output logic                  err_corrected_o,
	output ftalu_pkg::lane_mask_t permanent_fault_o,
	output ftalu_pkg::lane_mask_t fault_event_o
);

	// raw replica outputs before steering
	logic [ftalu_pkg::NUM_LANES-1:0][DATA_W-1:0] lane_result;
	ftalu_pkg::lane_mask_t                       lane_cmp;
	ftalu_pkg::lane_idx_t                        spare_idx;
	logic                                        cnt_clr;
	ftalu_pkg::lane_mask_t                       lane_err;

	//////////////////////////////
	// replicas
	//////////////////////////////

	// all lanes see the same operation, each has its own fault hook
	for (genvar g = 0; g < ftalu_pkg::NUM_LANES; g++) begin : gen_lane
		ftalu_lane_alu #(
			.DATA_W(DATA_W)
		) i_lane_alu (
			.op_i        (op_i),
			.operand_a_i (operand_a_i),
			.operand_b_i (operand_b_i),
			.inj_i       (inj_lane_i[g]),
			.result_o    (lane_result[g]),
			.cmp_o       (lane_cmp[g])
		);
	end

	// spare selection and counter clear
	ftalu_spare_cfg i_spare_cfg (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_spare_i (cfg_spare_i),
		.cfg_clr_i   (cfg_clr_i),
		.spare_idx_o (spare_idx),
		.clr_o       (cnt_clr)
	);

	//////////////////////////////
	// vote and bookkeeping
	//////////////////////////////

	ftalu_vote_stage #(
		.DATA_W(DATA_W)
	) i_vote_stage (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.valid_i         (valid_i),
		.ready_i         (ready_i),
		.lane_result_i   (lane_result),
		.lane_cmp_i      (lane_cmp),
		.spare_idx_i     (spare_idx),
		.ready_o         (ready_o),
		.valid_o         (valid_o),
		.result_o        (result_o),
		.cmp_o           (cmp_o),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o),
		.lane_err_o      (lane_err)
	);

	// spare lane never gets charged, so its counter stays idle
	ftalu_fault_counters #(
		.ERR_THRESHOLD (ERR_THRESHOLD),
		.CNT_W         (CNT_W)
	) i_fault_counters (
		.clk               (clk),
		.arst_n_i          (arst_n_i),
		.lane_err_i        (lane_err),
		.clr_i             (cnt_clr),
		.permanent_fault_o (permanent_fault_o),
		.fault_event_o     (fault_event_o)
	);

endmodule

/* test/ftalu_assertions.sv */
// concurrent assertions on the handshake, the vote flags and the fault event pulses of the top level
`timescale 1ns/1ps

module ftalu_assertions #(
	parameter int DATA_W = 32
) (
	input logic                  clk,
	input logic                  arst_n_i,
	input logic                  valid_i,
	input logic                  ready_i,
	input logic                  ready_o,
	input logic                  valid_o,
	input logic [DATA_W-1:0]     result_o,
	input logic                  cmp_o,
	input logic                  err_detected_o,
	input logic                  err_corrected_o,
	input ftalu_pkg::lane_mask_t inj_lane_i,
	input ftalu_pkg::lane_idx_t  spare_idx_i,
	input ftalu_pkg::lane_mask_t permanent_fault_o,
	input ftalu_pkg::lane_mask_t fault_event_o
);

	int                    fail_cnt = 0;
	ftalu_pkg::lane_mask_t active_inj;
	logic                  accept;

	// the spare lane feeds no slot, so only the other three count
	assign active_inj = inj_lane_i & ~(ftalu_pkg::lane_mask_t'(1) << spare_idx_i);
	assign accept     = valid_i && ready_o;

	//////////////////////////////
	// handshake
	//////////////////////////////

	a_ready_rule: assert property (@(posedge clk) disable iff (!arst_n_i)
		ready_o == (!valid_o || ready_i))
	else begin
		fail_cnt++;
		$error("ready_o does not follow the output register state");
	end

	// stalled beat and its flags are frozen
	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		(valid_o && !ready_i) |=> (valid_o && $stable(result_o) && $stable(cmp_o)
			&& $stable(err_detected_o) && $stable(err_corrected_o)))
	else begin
		fail_cnt++;
		$error("output beat changed while stalled");
	end

	a_reset_state: assert property (@(posedge clk)
		!arst_n_i |-> (!valid_o && !err_detected_o && !err_corrected_o
			&& (permanent_fault_o == '0) && (fault_event_o == '0)))
	else begin
		fail_cnt++;
		$error("outputs not idle during reset");
	end

	//////////////////////////////
	// vote flags
	//////////////////////////////

	a_clean_beat: assert property (@(posedge clk) disable iff (!arst_n_i)
		(accept && (active_inj == '0)) |=> (!err_detected_o && !err_corrected_o))
	else begin
		fail_cnt++;
		$error("error flags raised on a beat with no active lane faulted");
	end

	// one or two flipped slots always leave a majority
	a_fault_flags: assert property (@(posedge clk) disable iff (!arst_n_i)
		(accept && ($countones(active_inj) inside {1, 2})) |=> (err_detected_o && err_corrected_o))
	else begin
		fail_cnt++;
		$error("error flags missing on a beat with faulted active lanes");
	end

	//////////////////////////////
	// fault events
	//////////////////////////////

	for (genvar i = 0; i < ftalu_pkg::NUM_LANES; i++) begin : gen_lane_chk
		a_event_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
			fault_event_o[i] |-> (permanent_fault_o[i] ##1 !fault_event_o[i]))
		else begin
			fail_cnt++;
			$error("fault event on lane %0d is not a single pulse with its flag", i);
		end

		// sticky flag blocks any further event until a clear
		a_event_once: assert property (@(posedge clk) disable iff (!arst_n_i)
			permanent_fault_o[i] |=> !fault_event_o[i])
		else begin
			fail_cnt++;
			$error("second fault event on lane %0d while its flag was set", i);
		end
	end

endmodule

bind ftalu_top ftalu_assertions #(
	.DATA_W(DATA_W)
) i_ftalu_assertions (
	.clk               (clk),
	.arst_n_i          (arst_n_i),
	.valid_i           (valid_i),
	.ready_i           (ready_i),
	.ready_o           (ready_o),
	.valid_o           (valid_o),
	.result_o          (result_o),
	.cmp_o             (cmp_o),
	.err_detected_o    (err_detected_o),
	.err_corrected_o   (err_corrected_o),
	.inj_lane_i        (inj_lane_i),
	.spare_idx_i       (spare_idx),
	.permanent_fault_o (permanent_fault_o),
	.fault_event_o     (fault_event_o)
);

/* test/ftalu_tb.sv */
// testbench with clock, reset, random stimulus, reference model, scoreboard and watchdog
`timescale 1ns/1ps

module ftalu_tb;

	localparam int DATA_W         = 32;
	localparam int ERR_THRESHOLD  = 4;
	localparam int CNT_W          = 3;
	localparam int SHAMT_W        = $clog2(DATA_W);
	localparam int N_PER_OP       = 10;
	localparam int N_SINGLE       = 12;
	localparam int N_PER_SPARE    = 6;
	localparam int N_DOUBLE       = 6;
	localparam int N_STALL        = 4;
	localparam int TOTAL_BEATS    = 9 * N_PER_OP + N_SINGLE + 4 * N_PER_SPARE + N_DOUBLE
		+ ERR_THRESHOLD + N_STALL;
	localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 40 + 200;

	logic                  clk;
	logic                  arst_n_i;
	logic                  valid_i;
	ftalu_pkg::alu_op_t    op_i;
	logic [DATA_W-1:0]     operand_a_i;
	logic [DATA_W-1:0]     operand_b_i;
	logic                  ready_i;
	logic                  cfg_we_i;
	ftalu_pkg::lane_idx_t  cfg_spare_i;
	logic                  cfg_clr_i;
	ftalu_pkg::lane_mask_t inj_lane_i;
	logic                  ready_o;
	logic                  valid_o;
	logic [DATA_W-1:0]     result_o;
	logic                  cmp_o;
	logic                  err_detected_o;
	logic                  err_corrected_o;
	ftalu_pkg::lane_mask_t permanent_fault_o;
	ftalu_pkg::lane_mask_t fault_event_o;

	// expected beat is {result, cmp, detected, corrected}
	logic [DATA_W+2:0]    exp_q[$];
	logic [DATA_W+2:0]    exp_word;
	ftalu_pkg::lane_idx_t cur_spare;
	int                   mon_err_cnt = 0;
	int                   chk_err_cnt = 0;
	int                   event_cnt [ftalu_pkg::NUM_LANES];

	ftalu_top #(
		.DATA_W        (DATA_W),
		.ERR_THRESHOLD (ERR_THRESHOLD),
		.CNT_W         (CNT_W)
	) i_ftalu_top (.*);

	initial begin : clock_gen
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// returns {result, cmp} of one healthy lane
	function automatic logic [DATA_W:0] alu_model(input ftalu_pkg::alu_op_t op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		logic [DATA_W-1:0] r;
		logic              c;
		c = 1'b0;
		case (op)
			ftalu_pkg::ALU_ADD: r = a + b;
			ftalu_pkg::ALU_SUB: r = a - b;
			ftalu_pkg::ALU_AND: r = a & b;
			ftalu_pkg::ALU_OR:  r = a | b;
			ftalu_pkg::ALU_XOR: r = a ^ b;
			ftalu_pkg::ALU_SLL: r = a << b[SHAMT_W-1:0];
			ftalu_pkg::ALU_SRL: r = a >> b[SHAMT_W-1:0];
			ftalu_pkg::ALU_SLT: begin
				c = ($signed(a) < $signed(b));
				r = DATA_W'(c);
			end
			ftalu_pkg::ALU_SLTU: begin
				c = (a < b);
				r = DATA_W'(c);
			end
			default: r = '0;
		endcase
		return {r, c};
	endfunction

	// injection only flips result bit 0, so each slot is healthy or flipped
	function automatic logic [DATA_W+2:0] vote_model(input logic [DATA_W:0] good,
		input ftalu_pkg::lane_mask_t inj, input ftalu_pkg::lane_idx_t spare);
		logic [2:0] flip;
		logic       win;
		logic       det;
		logic       corr;
		for (int k = 0; k < 3; k++) begin
			flip[k] = (int'(spare) == k) ? inj[3] : inj[k];
		end
		det  = !((flip[0] == flip[1]) && (flip[1] == flip[2]));
		corr = det && ((flip[0] == flip[1]) || (flip[0] == flip[2]) || (flip[1] == flip[2]));
		if ((flip[0] == flip[1]) || (flip[0] == flip[2])) begin
			win = flip[0];
		end else if (flip[1] == flip[2]) begin
			win = flip[1];
		end else begin
			win = flip[0];
		end
		return {good ^ {{(DATA_W-1){1'b0}}, win, 1'b0}, det, corr};
	endfunction

	//////////////////////////////
	// scoreboard
	//////////////////////////////

	always @(posedge clk) begin
		if (arst_n_i) begin
			if (valid_o && ready_i) begin
				if (exp_q.size() == 0) begin
					mon_err_cnt++;
					$display("output beat at %0t with no accepted beat waiting", $time);
				end else begin
					exp_word = exp_q.pop_front();
					if ({result_o, cmp_o} != exp_word[DATA_W+2:2]) begin
						mon_err_cnt++;
						$display("MISMATCH at %0t: result %h cmp %b, expected %h cmp %b", $time,
							result_o, cmp_o, exp_word[DATA_W+2:3], exp_word[2]);
					end
					if ({err_detected_o, err_corrected_o} != exp_word[1:0]) begin
						mon_err_cnt++;
						$display("MISMATCH at %0t: flags det %b corr %b, expected %b", $time,
							err_detected_o, err_corrected_o, exp_word[1:0]);
					end
				end
			end
			if (valid_i && ready_o) begin
				exp_q.push_back(vote_model(alu_model(op_i, operand_a_i, operand_b_i),
					inj_lane_i, cur_spare));
			end
			// event tally restarts with each counter clear
			for (int i = 0; i < ftalu_pkg::NUM_LANES; i++) begin
				if (cfg_clr_i) begin
					event_cnt[i] = 0;
				end else if (fault_event_o[i]) begin
					event_cnt[i]++;
				end
			end
		end
	end

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////

	// called 2 ns after an edge, returns 2 ns after the accepting edge
	task automatic send_beat(input ftalu_pkg::alu_op_t op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input ftalu_pkg::lane_mask_t inj);
		logic taken;
		valid_i     = 1'b1;
		op_i        = op;
		operand_a_i = a;
		operand_b_i = b;
		inj_lane_i  = inj;
		taken       = 1'b0;
		while (!taken) begin
			#1;
			taken = ready_o;
			@(posedge clk);
			#2;
		end
		valid_i    = 1'b0;
		inj_lane_i = '0;
	endtask

	task automatic send_random(input ftalu_pkg::lane_mask_t inj);
		send_beat(ftalu_pkg::alu_op_t'(4'($urandom_range(0, 8))), $urandom, $urandom, inj);
	endtask

	// wait for all beats to leave, then for the counters to settle
	task automatic drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
		repeat (3) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic set_spare(input ftalu_pkg::lane_idx_t idx);
		drain();
		cfg_we_i    = 1'b1;
		cfg_spare_i = idx;
		@(posedge clk);
		#2;
		cfg_we_i  = 1'b0;
		cur_spare = idx;
	endtask

	task automatic clear_counters();
		drain();
		cfg_clr_i = 1'b1;
		@(posedge clk);
		#2;
		cfg_clr_i = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic check_value(input string what, input int got, input int expected);
		if (got != expected) begin
			chk_err_cnt++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin : main
		ftalu_pkg::alu_op_t op;
		logic [DATA_W-1:0]  a;
		logic [DATA_W-1:0]  b;
		int                 asrt_cnt;
		void'($urandom(32'hbc64));
		arst_n_i    = 1'b0;
		valid_i     = 1'b0;
		op_i        = ftalu_pkg::ALU_ADD;
		operand_a_i = '0;
		operand_b_i = '0;
		ready_i     = 1'b1;
		cfg_we_i    = 1'b0;
		cfg_spare_i = 2'd3;
		cfg_clr_i   = 1'b0;
		inj_lane_i  = '0;
		cur_spare   = 2'd3;
		repeat (10) @(posedge clk);
		#2;
		arst_n_i = 1'b1;
		@(posedge clk);
		#2;

		// fault-free, every operation
		for (int o = 0; o < 9; o++) begin
			for (int n = 0; n < N_PER_OP; n++) begin
				send_beat(ftalu_pkg::alu_op_t'(4'(o)), $urandom, $urandom, '0);
			end
		end

		// one active lane flipped
		for (int n = 0; n < N_SINGLE; n++) begin
			send_random(ftalu_pkg::lane_mask_t'(1 << $urandom_range(0, 2)));
		end

		// two active lanes agree on the wrong bit
		for (int n = 0; n < N_DOUBLE; n++) begin
			send_random(4'b0111 & ~ftalu_pkg::lane_mask_t'(1 << $urandom_range(0, 2)));
		end

		// faults on the spare lane only
		clear_counters();
		for (int s = 0; s < 4; s++) begin
			set_spare(ftalu_pkg::lane_idx_t'(s));
			for (int n = 0; n < N_PER_SPARE; n++) begin
				send_random(ftalu_pkg::lane_mask_t'(1 << s));
			end
		end
		drain();
		check_value("permanent fault mask after spare faults", int'(permanent_fault_o), 0);

		// lane 1 reaches the threshold
		set_spare(2'd3);
		clear_counters();
		for (int n = 0; n < ERR_THRESHOLD; n++) begin
			send_random(4'b0010);
		end
		drain();
		check_value("permanent fault mask", int'(permanent_fault_o), 2);
		check_value("fault events on lane 1", event_cnt[1], 1);
		check_value("fault events on other lanes", event_cnt[0] + event_cnt[2] + event_cnt[3], 0);
		clear_counters();
		check_value("permanent fault mask after clear", int'(permanent_fault_o), 0);

		// output stalled with a second beat waiting at the input
		for (int n = 0; n < N_STALL / 2; n++) begin
			// first beat may enter while the previous one is still leaving
			send_random(4'b0001);
			ready_i     = 1'b0;
			op          = ftalu_pkg::alu_op_t'(4'($urandom_range(0, 8)));
			a           = $urandom;
			b           = $urandom;
			valid_i     = 1'b1;
			op_i        = op;
			operand_a_i = a;
			operand_b_i = b;
			repeat (5) begin
				@(posedge clk);
				#2;
			end
			ready_i = 1'b1;
			send_beat(op, a, b, '0);
		end
		drain();

		asrt_cnt = i_ftalu_top.i_ftalu_assertions.fail_cnt;
		$display("errors: %0d scoreboard, %0d checks, %0d assertions",
			mon_err_cnt, chk_err_cnt, asrt_cnt);
		if ((mon_err_cnt + chk_err_cnt + asrt_cnt) == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("run timed out after %0d cycles before the tests finished", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* sources.f */
rtl/ftalu_pkg.sv
rtl/ftalu_lane_alu.sv
rtl/ftalu_spare_cfg.sv
rtl/ftalu_vote_stage.sv
rtl/ftalu_fault_counters.sv
rtl/ftalu_top.sv
test/ftalu_assertions.sv
test/ftalu_tb.sv

/* Makefile */
# Verilator build and run for the fault-tolerant ALU

VERILATOR ?= verilator
TOP       ?= ftalu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
